// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module timer_tb -f src.f -o timer_sim \
	&& ./obj_dir/timer_sim > sim.log 2>&1
grep -q "^No errors$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== src.f ====
src/timer_pkg.sv
src/div_counter.sv
src/timer.sv
src/io_bus_decode.sv
src/interrupt_flag.sv
src/timer_top.sv
testbench/timer_properties.sv
testbench/timer_tb.sv

// ==== src/div_counter.sv ====
module div_counter
	import timer_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  logic       div_wr,
	output logic [7:0] div_value,
	output logic       tap_4096,
	output logic       tap_16384,
	output logic       tap_65536,
	output logic       tap_262144
);

	logic [prescale_width-1:0] prescale;

	// Prescaler bit that clocks each TAC rate
	function automatic int tap_index(rate_t r);
		int idx;
		case (r)
			rate_4096:   idx = 7;
			rate_16384:  idx = 5;
			rate_65536:  idx = 3;
			rate_262144: idx = 1;
			default:     idx = 7;
		endcase
		return idx;
	endfunction

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			prescale <= '0;
		end else if (div_wr) begin
			prescale <= '0;   // Any write to DIV clears the whole chain
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// Upper byte of the prescaler, steps every 64 cycles
	assign div_value = prescale[prescale_width-1 -: 8];

	assign tap_4096   = prescale[tap_index(rate_4096)];
	assign tap_16384  = prescale[tap_index(rate_16384)];
	assign tap_65536  = prescale[tap_index(rate_65536)];
	assign tap_262144 = prescale[tap_index(rate_262144)];

endmodule

// ==== src/interrupt_flag.sv ====
module interrupt_flag (
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  logic       timer_int,
	input  logic       irq_ack,
	input  logic       if_wr,
	input  logic [7:0] wr_data,
	output logic       irq_timer,
	output logic [7:0] if_value
);

	logic req_q;
	logic req_clr;

	// CPU service or software clear through FF0F
	assign req_clr = irq_ack || (if_wr && !wr_data[2]);

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			req_q <= 1'b0;
		end else if (timer_int) begin
			req_q <= 1'b1;   // New request beats a same-cycle clear
		end else if (req_clr) begin
			req_q <= 1'b0;
		end
	end

	assign irq_timer = req_q;

	// Top three bits are not implemented and read high
	assign if_value = {3'b111, 2'b00, req_q, 2'b00};

endmodule

// ==== src/io_bus_decode.sv ====
module io_bus_decode
	import timer_pkg::*;
(
	input  logic [15:0] addr,
	input  logic        wr,
	input  logic        rd,
	output logic        div_wr,
	output logic        tima_wr,
	output logic        tma_wr,
	output logic        tac_wr,
	output logic        if_wr,
	input  logic [7:0]  div_value,
	input  logic [7:0]  tima_value,
	input  logic [7:0]  tma_value,
	input  tac_t        tac_value,
	input  logic [7:0]  if_value,
	output logic [7:0]  rd_data
);

	logic sel_div;
	logic sel_tima;
	logic sel_tma;
	logic sel_tac;
	logic sel_if;
	logic div_rd;
	logic tima_rd;
	logic tma_rd;
	logic tac_rd;
	logic if_rd;
	tac_t tac_view;

	assign sel_div  = (addr == addr_div);
	assign sel_tima = (addr == addr_tima);
	assign sel_tma  = (addr == addr_tma);
	assign sel_tac  = (addr == addr_tac);
	assign sel_if   = (addr == addr_if);

	// Write strobes, one-hot by construction
	assign div_wr  = wr & sel_div;
	assign tima_wr = wr & sel_tima;
	assign tma_wr  = wr & sel_tma;
	assign tac_wr  = wr & sel_tac;
	assign if_wr   = wr & sel_if;

	assign div_rd  = rd & sel_div;
	assign tima_rd = rd & sel_tima;
	assign tma_rd  = rd & sel_tma;
	assign tac_rd  = rd & sel_tac;
	assign if_rd   = rd & sel_if;

	always_comb begin
		tac_view          = tac_value;
		tac_view.f.unused = '1;   // Unimplemented TAC bits
		rd_data           = 8'hFF;   // Pulled-up bus when nothing drives it
		if (div_rd)
			rd_data = div_value;
		else if (tima_rd)
			rd_data = tima_value;
		else if (tma_rd)
			rd_data = tma_value;
		else if (tac_rd)
			rd_data = tac_view.raw;
		else if (if_rd)
			rd_data = if_value;
	end

endmodule

// ==== src/timer.sv ====
module timer
	import timer_pkg::*;
#(
	parameter int reload_delay = 1
) (
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  logic [7:0] wr_data,
	input  logic       tima_wr,
	input  logic       tma_wr,
	input  logic       tac_wr,
	input  logic       tap_4096,
	input  logic       tap_16384,
	input  logic       tap_65536,
	input  logic       tap_262144,
	output logic [7:0] tima_value,
	output logic [7:0] tma_value,
	output logic [7:0] tac_value,
	output logic       timer_int
);

	localparam int cnt_w = (reload_delay > 1) ? $clog2(reload_delay + 1) : 1;

	tac_t             tac_q;
	logic [7:0]       tma_q;
	logic [7:0]       tma_fwd;
	logic [7:0]       tima_q;
	logic             tap_sel;
	logic             tap_gated;
	logic             tap_q;
	logic             tima_inc;
	logic             tima_ovf;
	logic             reload_now;
	logic [cnt_w-1:0] delay_cnt;

	// ****************************************
	// TAC and TMA
	// ****************************************

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			tac_q.raw <= 8'hF8;
			tma_q     <= '0;
		end else begin
			if (tac_wr)
				tac_q.raw <= wr_data;
			if (tma_wr)
				tma_q <= wr_data;
		end
	end

	// New TMA value wins when written in the reload cycle
	assign tma_fwd = tma_wr ? wr_data : tma_q;

	// ****************************************
	// Rate select and edge detect
	// ****************************************

	always_comb begin
		case (tac_q.f.rate_sel)
			rate_4096:   tap_sel = tap_4096;
			rate_262144: tap_sel = tap_262144;
			rate_65536:  tap_sel = tap_65536;
			rate_16384:  tap_sel = tap_16384;
			default:     tap_sel = tap_4096;
		endcase
	end

	assign tap_gated = tap_sel & tac_q.f.enable;

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			tap_q <= 1'b0;
		end else begin
			tap_q <= tap_gated;
		end
	end

	// Falling edge, so a DIV write or a TAC change can also tick
	assign tima_inc = tap_q & ~tap_gated;
	assign tima_ovf = tima_inc && (tima_q == 8'hFF);

	// ****************************************
	// TIMA, overflow delay and reload
	// ****************************************

	always_comb begin
		if (reload_delay == 0)
			reload_now = tima_ovf && !tima_wr;
		else
			reload_now = (delay_cnt == cnt_w'(1)) && !tima_wr;
	end

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			delay_cnt <= '0;
		end else if (tima_wr) begin
			delay_cnt <= '0;   // CPU write aborts the pending reload
		end else if (delay_cnt != '0) begin
			delay_cnt <= delay_cnt - 1'b1;
		end else if (tima_ovf && reload_delay != 0) begin
			delay_cnt <= cnt_w'(reload_delay);
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			tima_q <= '0;
		end else if (tima_wr) begin
			tima_q <= wr_data;
		end else if (reload_now) begin
			tima_q <= tma_fwd;
		end else if (tima_inc) begin
			tima_q <= tima_q + 8'd1;   // Wraps to 00 on overflow
		end
	end

	// High in the first cycle TIMA shows the reloaded value
	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			timer_int <= 1'b0;
		end else begin
			timer_int <= reload_now;
		end
	end

	assign tima_value = tima_q;
	assign tma_value  = tma_q;
	assign tac_value  = tac_q.raw;

endmodule

// ==== src/timer_pkg.sv ====
package timer_pkg;

	// ****************************************
	// Register map
	// ****************************************

	localparam logic [15:0] addr_div  = 16'hFF04;
	localparam logic [15:0] addr_tima = 16'hFF05;
	localparam logic [15:0] addr_tma  = 16'hFF06;
	localparam logic [15:0] addr_tac  = 16'hFF07;
	localparam logic [15:0] addr_if   = 16'hFF0F;

	// Set by the console clock ratios
	localparam int prescale_width = 14;

	// ****************************************
	// TAC encoding
	// ****************************************

	typedef enum logic [1:0] {
		rate_4096   = 2'b00,
		rate_262144 = 2'b01,
		rate_65536  = 2'b10,
		rate_16384  = 2'b11
	} rate_t;

	typedef struct packed {
		logic [4:0] unused;   // Reads back as ones
		logic       enable;
		rate_t      rate_sel;
	} tac_fields_t;

	// Raw byte from the bus, or the decoded fields
	typedef union packed {
		logic [7:0]  raw;
		tac_fields_t f;
	} tac_t;

endpackage

// ==== src/timer_top.sv ====
module timer_top #(
	parameter int reload_delay = 1
) (
	input  logic        boga1mhz,
	input  logic        rst_n,
	input  logic [15:0] addr,
	input  logic        wr,
	input  logic        rd,
	input  logic [7:0]  wr_data,
	output logic [7:0]  rd_data,
	output logic        irq_timer,
	input  logic        irq_ack
);

	logic       div_wr;
	logic       tima_wr;
	logic       tma_wr;
	logic       tac_wr;
	logic       if_wr;
	logic [7:0] div_value;
	logic [7:0] tima_value;
	logic [7:0] tma_value;
	logic [7:0] tac_value;
	logic [7:0] if_value;
	logic       tap_4096;
	logic       tap_16384;
	logic       tap_65536;
	logic       tap_262144;
	logic       timer_int;

	// ****************************************
	// CPU side
	// ****************************************

	io_bus_decode bus_i (
		.addr       (addr),
		.wr         (wr),
		.rd         (rd),
		.div_wr     (div_wr),
		.tima_wr    (tima_wr),
		.tma_wr     (tma_wr),
		.tac_wr     (tac_wr),
		.if_wr      (if_wr),
		.div_value  (div_value),
		.tima_value (tima_value),
		.tma_value  (tma_value),
		.tac_value  (tac_value),
		.if_value   (if_value),
		.rd_data    (rd_data)
	);

	interrupt_flag if_i (
		.boga1mhz  (boga1mhz),
		.rst_n     (rst_n),
		.timer_int (timer_int),
		.irq_ack   (irq_ack),
		.if_wr     (if_wr),
		.wr_data   (wr_data),
		.irq_timer (irq_timer),
		.if_value  (if_value)
	);

	// ****************************************
	// Divider and timer
	// ****************************************

	div_counter div_i (
		.boga1mhz   (boga1mhz),
		.rst_n      (rst_n),
		.div_wr     (div_wr),
		.div_value  (div_value),
		.tap_4096   (tap_4096),
		.tap_16384  (tap_16384),
		.tap_65536  (tap_65536),
		.tap_262144 (tap_262144)
	);

	timer #(
		.reload_delay (reload_delay)
	) timer_i (
		.boga1mhz   (boga1mhz),
		.rst_n      (rst_n),
		.wr_data    (wr_data),
		.tima_wr    (tima_wr),
		.tma_wr     (tma_wr),
		.tac_wr     (tac_wr),
		.tap_4096   (tap_4096),
		.tap_16384  (tap_16384),
		.tap_65536  (tap_65536),
		.tap_262144 (tap_262144),
		.tima_value (tima_value),
		.tma_value  (tma_value),
		.tac_value  (tac_value),
		.timer_int  (timer_int)
	);

endmodule

// ==== testbench/timer_properties.sv ====
module timer_properties #(
	parameter int reload_delay = 1
) (
	input logic       boga1mhz,
	input logic       rst_n,
	input logic       tima_wr,
	input logic       tima_inc,
	input logic       tima_ovf,
	input logic [7:0] tac_value,
	input logic [7:0] tima_value,
	input logic [7:0] tma_value,
	input logic       timer_int
);

	logic [7:0] wrap_age;   // Counts cycles after a TIMA wrap
	logic       reload_due;
	logic       due_next;

	assign due_next = !tima_wr
		&& ((reload_delay == 0) ? tima_ovf : (wrap_age == 8'(reload_delay)));

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			wrap_age   <= '0;
			reload_due <= 1'b0;
		end else begin
			reload_due <= due_next;
			if (tima_wr || due_next)
				wrap_age <= '0;
			else if (wrap_age != '0)
				wrap_age <= wrap_age + 8'd1;
			else if (tima_ovf && reload_delay != 0)
				wrap_age <= 8'd1;
		end
	end

	int_single_cycle: assert property (@(posedge boga1mhz) disable iff (!rst_n)
		timer_int |=> !timer_int)
		else $error("timer_int stayed high for a second cycle");

	// Enable low with TAC untouched
	no_tick_when_off: assert property (@(posedge boga1mhz) disable iff (!rst_n)
		(!tac_value[2] && $stable(tac_value)) |-> !tima_inc)
		else $error("TIMA ticked while the timer was disabled");

	// TMA register already holds any value written in the reload cycle
	reload_from_tma: assert property (@(posedge boga1mhz) disable iff (!rst_n)
		reload_due |-> (tima_value == tma_value) && timer_int)
		else $error("TIMA was not reloaded from TMA on time");

endmodule

bind timer timer_properties #(
	.reload_delay (reload_delay)
) props_i (
	.boga1mhz   (boga1mhz),
	.rst_n      (rst_n),
	.tima_wr    (tima_wr),
	.tima_inc   (tima_inc),
	.tima_ovf   (tima_ovf),
	.tac_value  (tac_value),
	.tima_value (tima_value),
	.tma_value  (tma_value),
	.timer_int  (timer_int)
);

// ==== testbench/timer_tb.sv ====
module timer_tb;

	localparam string trace_file = "testbench/timer_trace.txt";

	logic        boga1mhz;
	logic        rst_n;
	logic [15:0] addr;
	logic        wr;
	logic        rd;
	logic [7:0]  wr_data;
	logic [7:0]  rd_data;
	logic        irq_timer;
	logic        irq_ack;

	// Whole trace is loaded up front so the cycle limit is known
	logic [7:0]  op_q[$];
	logic [15:0] addr_q[$];
	logic [15:0] data_q[$];
	logic [7:0]  exp_q[$];
	int          cycle_cnt;
	int          cycle_limit;
	string       problem;

	timer_top #(
		.reload_delay (1)
	) dut_i (
		.boga1mhz  (boga1mhz),
		.rst_n     (rst_n),
		.addr      (addr),
		.wr        (wr),
		.rd        (rd),
		.wr_data   (wr_data),
		.rd_data   (rd_data),
		.irq_timer (irq_timer),
		.irq_ack   (irq_ack)
	);

	initial begin
		boga1mhz = 1'b0;
		forever #10 boga1mhz = ~boga1mhz;
	end

	always @(posedge boga1mhz) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: trace still running after %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1, "Cycle limit reached");
		end
	end

	// ****************************************
	// Helpers
	// ****************************************

	task automatic check_value(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s is %h, expected %h", name, actual, expected);
			$display("Errors found");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic load_trace(output string msg);
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [15:0] a;
		logic [15:0] d;
		logic [7:0]  e;
		msg = "";
		fd = $fopen(trace_file, "r");
		if (fd == 0) begin
			msg = {"cannot open ", trace_file};
		end else begin
			while (msg == "" && $fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%c %h %h %h", op, a, d, e);
					if (n != 4 || !(op inside {"W", "R", "I", "Q", "A"})) begin
						msg = {"bad trace line: ", line};
					end else begin
						op_q.push_back(op);
						addr_q.push_back(a);
						data_q.push_back(d);
						exp_q.push_back(e);
						if (op == "I")
							cycle_limit = cycle_limit + int'(d);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One bus cycle per operation, idle ops take data cycles
	task automatic run_op(input logic [7:0] op, input logic [15:0] a,
			input logic [15:0] d, input logic [7:0] e);
		addr    = a;
		wr_data = d[7:0];
		wr      = (op == "W");
		rd      = (op == "R");
		irq_ack = (op == "A");
		if (op == "I") begin
			repeat (d) @(negedge boga1mhz);
		end else begin
			#5;   // Mid low phase, before the next rising edge
			if (op == "R")
				check_value($sformatf("rd_data (%h)", a), rd_data, e);
			else if (op == "Q")
				check_value("irq_timer", {7'b0, irq_timer}, e);
			@(negedge boga1mhz);
		end
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial begin
		cycle_cnt   = 0;
		cycle_limit = 200;
		rst_n       = 1'b0;
		addr        = '0;
		wr          = 1'b0;
		rd          = 1'b0;
		wr_data     = '0;
		irq_ack     = 1'b0;
		load_trace(problem);
		if (problem != "") begin
			$display("Stimulus unusable, %s", problem);
			$display("Errors found");
			$fatal(1, "No stimulus");
		end else begin
			repeat (5) @(posedge boga1mhz);
			@(negedge boga1mhz);
			rst_n = 1'b1;
			for (int i = 0; i < op_q.size(); i++)
				run_op(op_q[i], addr_q[i], data_q[i], exp_q[i]);
			$display("No errors");
			$finish;
		end
	end

endmodule

// ==== testbench/timer_trace.txt ====
# op addr data expect, all hex
# W write, R read and compare, I idle for data cycles, Q irq_timer level, A irq_ack pulse
# Reset values
R FF04 00 00
R FF05 00 00
R FF06 00 00
R FF07 00 F8
R FF0F 00 E0
Q 0000 00 00
# DIV clear and count
W FF04 AB 00
R FF04 00 00
I 0000 80 00
R FF04 00 02
# Resync prescaler, TAC 05, count from 00
W FF04 00 00
W FF07 05 00
W FF05 00 00
I 0000 28 00
R FF05 00 0A
# Overflow and reload from TMA
W FF06 C0 00
W FF05 FE 00
I 0000 08 00
R FF05 00 00
R FF05 00 C0
Q 0000 00 01
# Clear through FF0F
W FF0F 00 00
R FF0F 00 E0
Q 0000 00 00
# TIMA write in the delay cycle
W FF05 FE 00
I 0000 04 00
R FF05 00 FF
W FF05 55 00
R FF05 00 55
I 0000 03 00
Q 0000 00 00
# Overflow again, clear with irq_ack
W FF05 FF 00
I 0000 03 00
Q 0000 00 01
A 0000 00 00
Q 0000 00 00
R FF0F 00 E0
# Disable, one glitch tick, then frozen
W FF07 00 00
I 0000 02 00
R FF05 00 C2
I 0000 12C 00
R FF05 00 C2
R FF07 00 F8
